/* compile.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_regfile.sv
rtl/cpu_alu.sv
rtl/cpu_decoder.sv
rtl/cpu_mem_ctrl.sv
rtl/cpu_core_ctrl.sv
rtl/cpu.sv
verification/cpu_tb.sv

/* rtl/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu (
  input  wire                  clk_in,
  input  wire                  rst_in,
  input  wire                  rdy_in,   // pauses the whole core when low
  input  wire  [7:0]           mem_din_i,
  output logic [7:0]           mem_dout_o,
  output logic [`CPU_XLEN-1:0] mem_a_o,
  output logic                 mem_wr_o, // 1 for write
  output logic [`CPU_XLEN-1:0] dbgreg_dout_o
);

  logic [`CPU_XLEN-1:0] inst;
  logic [`CPU_XLEN-1:0] pc;
  logic [`CPU_XLEN-1:0] imm;
  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic [`CPU_XLEN-1:0] alu_a;
  logic [`CPU_XLEN-1:0] alu_b;
  logic [`CPU_XLEN-1:0] alu_result;
  logic [`CPU_XLEN-1:0] mem_addr;
  logic [`CPU_XLEN-1:0] mem_wdata;
  logic [`CPU_XLEN-1:0] mem_rdata;
  logic [`CPU_XLEN-1:0] rd_data;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  logic                 b_is_imm;
  logic                 branch_eq;
  logic                 mem_done;
  logic                 rd_we;
  cpu_pkg::alu_op_e     alu_op;
  cpu_pkg::inst_class_e inst_class;
  cpu_pkg::mem_op_e     mem_op;

  // operand select, pc feeds the jal link
  assign alu_a = (alu_op == cpu_pkg::alu_pc_plus4) ? pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  cpu_core_ctrl u_core (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_i(rdy_in),
    .class_i(inst_class), .imm_i(imm),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .alu_result_i(alu_result), .branch_eq_i(branch_eq),
    .mem_done_i(mem_done), .mem_rdata_i(mem_rdata),
    .inst_o(inst), .pc_o(pc),
    .mem_op_o(mem_op), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .rd_we_o(rd_we), .rd_data_o(rd_data)
  );

  cpu_decoder u_dec (
    .inst_i(inst), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .alu_op_o(alu_op), .class_o(inst_class), .b_is_imm_o(b_is_imm)
  );

  cpu_regfile u_rf (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_i(rdy_in),
    .raddr1_i(rs1), .raddr2_i(rs2),
    .we_i(rd_we), .waddr_i(rd), .wdata_i(rd_data),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data), .dbg_o(dbgreg_dout_o)
  );

  cpu_alu u_alu (
    .op_i(alu_op), .a_i(alu_a), .b_i(alu_b),
    .result_o(alu_result), .equal_o(branch_eq)
  );

  cpu_mem_ctrl u_mem (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_i(rdy_in),
    .op_i(mem_op), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .mem_din_i(mem_din_i),
    .done_o(mem_done), .rdata_o(mem_rdata),
    .mem_a_o(mem_a_o), .mem_dout_o(mem_dout_o), .mem_wr_o(mem_wr_o)
  );

endmodule

`default_nettype wire

/* rtl/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_alu (
  input  wire cpu_pkg::alu_op_e op_i,
  input  wire  [`CPU_XLEN-1:0]  a_i,
  input  wire  [`CPU_XLEN-1:0]  b_i,
  output logic [`CPU_XLEN-1:0]  result_o,
  output logic                  equal_o
);

  localparam logic [`CPU_XLEN-1:0] inst_bytes = 4;

  logic less_than;

  assign less_than = $signed(a_i) < $signed(b_i);
  assign equal_o   = (a_i == b_i); // beq and bne

  always_comb
  begin
    case (op_i)
      cpu_pkg::alu_add:      result_o = a_i + b_i;
      cpu_pkg::alu_sub:      result_o = a_i - b_i;
      cpu_pkg::alu_and:      result_o = a_i & b_i;
      cpu_pkg::alu_or:       result_o = a_i | b_i;
      cpu_pkg::alu_xor:      result_o = a_i ^ b_i;
      cpu_pkg::alu_slt:      result_o = {{(`CPU_XLEN-1){1'b0}}, less_than};
      cpu_pkg::alu_pass_b:   result_o = b_i;             // upper immediate
      cpu_pkg::alu_pc_plus4: result_o = a_i + inst_bytes; // a is the pc here
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width of the core
`define CPU_XLEN 32

`define CPU_RESET_PC 32'h0000_0000 // first fetch address

// memory mapped i/o, decoded by the memory model and not by the core
`define CPU_IO_OUT_ADDR  32'h0003_0000 // byte written here goes to the output log
`define CPU_IO_STOP_ADDR 32'h0003_0004 // any write here stops the program

// register shown on dbgreg_dout, a0
`define CPU_DBG_REG 10

`endif

/* rtl/cpu_core_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_core_ctrl (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       rdy_i,
  input  wire cpu_pkg::inst_class_e class_i,
  input  wire  [`CPU_XLEN-1:0]      imm_i,
  input  wire  [`CPU_XLEN-1:0]      rs1_data_i,
  input  wire  [`CPU_XLEN-1:0]      rs2_data_i,
  input  wire  [`CPU_XLEN-1:0]      alu_result_i,
  input  wire                       branch_eq_i,
  input  wire                       mem_done_i,
  input  wire  [`CPU_XLEN-1:0]      mem_rdata_i,
  output logic [`CPU_XLEN-1:0]      inst_o,
  output logic [`CPU_XLEN-1:0]      pc_o,
  output cpu_pkg::mem_op_e          mem_op_o,
  output logic [`CPU_XLEN-1:0]      mem_addr_o,
  output logic [`CPU_XLEN-1:0]      mem_wdata_o,
  output logic                      rd_we_o,
  output logic [`CPU_XLEN-1:0]      rd_data_o
);

  localparam logic [`CPU_XLEN-1:0] inst_bytes = 4;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_exec,
    st_mem,
    st_wb,
    st_halt
  } state_e;

  state_e               state_q;
  logic [`CPU_XLEN-1:0] rs1_q;
  logic [`CPU_XLEN-1:0] rs2_q;
  logic [`CPU_XLEN-1:0] addr_q;    // load/store effective address
  logic [`CPU_XLEN-1:0] result_q;  // alu result or load data
  logic [`CPU_XLEN-1:0] next_pc_q;
  logic                 is_mem;
  logic                 writes_rd;
  logic                 take_jump;

  assign is_mem    = class_i inside {cpu_pkg::cls_load, cpu_pkg::cls_store_word,
                                     cpu_pkg::cls_store_byte};
  assign writes_rd = class_i inside {cpu_pkg::cls_reg_alu, cpu_pkg::cls_imm_alu,
                                     cpu_pkg::cls_lui, cpu_pkg::cls_load, cpu_pkg::cls_jal};
  assign take_jump = (class_i == cpu_pkg::cls_jal) ||
                     ((class_i == cpu_pkg::cls_branch_eq) && branch_eq_i) ||
                     ((class_i == cpu_pkg::cls_branch_ne) && !branch_eq_i);

  always_comb
  begin
    mem_op_o = cpu_pkg::mem_none;
    if (state_q == st_fetch)
      mem_op_o = cpu_pkg::mem_fetch;
    else if (state_q == st_mem)
    begin
      case (class_i)
        cpu_pkg::cls_load:       mem_op_o = cpu_pkg::mem_load_word;
        cpu_pkg::cls_store_word: mem_op_o = cpu_pkg::mem_store_word;
        cpu_pkg::cls_store_byte: mem_op_o = cpu_pkg::mem_store_byte;
        default:                 mem_op_o = cpu_pkg::mem_none;
      endcase
    end
  end

  assign mem_addr_o  = (state_q == st_fetch) ? pc_o : addr_q;
  assign mem_wdata_o = rs2_q;
  assign rd_we_o     = (state_q == st_wb) && writes_rd;
  assign rd_data_o   = result_q;

  // sequencer and pc
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state_q <= st_fetch;
      pc_o    <= `CPU_RESET_PC;
    end
    else if (rdy_i)
    begin
      case (state_q)
        st_fetch:
          if (mem_done_i)
            state_q <= st_decode;
        st_decode: state_q <= (class_i == cpu_pkg::cls_illegal) ? st_halt : st_exec;
        st_exec:   state_q <= is_mem ? st_mem : st_wb;
        st_mem:
          if (mem_done_i)
            state_q <= st_wb;
        st_wb:
        begin
          pc_o    <= next_pc_q;
          state_q <= st_fetch;
        end
        default: state_q <= st_halt; // stays here until reset
      endcase
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      case (state_q)
        st_fetch:
          if (mem_done_i)
            inst_o <= mem_rdata_i;
        st_decode:
        begin
          rs1_q <= rs1_data_i;
          rs2_q <= rs2_data_i; // store data
        end
        st_exec:
        begin
          result_q  <= alu_result_i;
          addr_q    <= rs1_q + imm_i;
          next_pc_q <= take_jump ? (pc_o + imm_i) : (pc_o + inst_bytes);
        end
        st_mem:
          if (mem_done_i && (class_i == cpu_pkg::cls_load))
            result_q <= mem_rdata_i;
        default: ;
      endcase
    end
  end

  // decoder output checked against the sequencer step that consumes it
  a_legal_inst: assert property (@(posedge clk_in) disable iff (rst_in)
    (state_q == st_decode) |-> (class_i != cpu_pkg::cls_illegal))
    else $error("illegal instruction %h at pc %h", inst_o, pc_o);

endmodule

`default_nettype wire

/* rtl/cpu_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_decoder (
  input  wire  [`CPU_XLEN-1:0]   inst_i,
  output logic [4:0]             rs1_o,
  output logic [4:0]             rs2_o,
  output logic [4:0]             rd_o,
  output logic [`CPU_XLEN-1:0]   imm_o,
  output cpu_pkg::alu_op_e       alu_op_o,
  output cpu_pkg::inst_class_e   class_o,
  output logic                   b_is_imm_o
);

  cpu_pkg::opcode_e     opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`CPU_XLEN-1:0] imm_i_type;
  logic [`CPU_XLEN-1:0] imm_s_type;
  logic [`CPU_XLEN-1:0] imm_b_type;
  logic [`CPU_XLEN-1:0] imm_u_type;
  logic [`CPU_XLEN-1:0] imm_j_type;

  assign opcode = cpu_pkg::opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign rd_o   = inst_i[11:7];

  // sign-extended immediates, one per format
  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  always_comb
  begin
    alu_op_o   = cpu_pkg::alu_add;
    class_o    = cpu_pkg::cls_illegal;
    b_is_imm_o = 1'b0;
    imm_o      = imm_i_type;
    case (opcode)
      cpu_pkg::op_imm:
      begin
        b_is_imm_o = 1'b1;
        class_o    = cpu_pkg::cls_imm_alu;
        case (funct3)
          3'b000:  alu_op_o = cpu_pkg::alu_add;
          3'b111:  alu_op_o = cpu_pkg::alu_and;
          3'b110:  alu_op_o = cpu_pkg::alu_or;
          3'b100:  alu_op_o = cpu_pkg::alu_xor;
          default: class_o  = cpu_pkg::cls_illegal; // shifts and compares not supported
        endcase
      end
      cpu_pkg::op_reg:
      begin
        class_o = cpu_pkg::cls_reg_alu;
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = cpu_pkg::alu_add;
          10'b0100000_000: alu_op_o = cpu_pkg::alu_sub;
          10'b0000000_111: alu_op_o = cpu_pkg::alu_and;
          10'b0000000_110: alu_op_o = cpu_pkg::alu_or;
          10'b0000000_100: alu_op_o = cpu_pkg::alu_xor;
          10'b0000000_010: alu_op_o = cpu_pkg::alu_slt;
          default:         class_o  = cpu_pkg::cls_illegal;
        endcase
      end
      cpu_pkg::op_lui:
      begin
        imm_o      = imm_u_type;
        b_is_imm_o = 1'b1;
        alu_op_o   = cpu_pkg::alu_pass_b;
        class_o    = cpu_pkg::cls_lui;
      end
      cpu_pkg::op_load:
      begin
        b_is_imm_o = 1'b1;
        if (funct3 == 3'b010)
          class_o = cpu_pkg::cls_load; // lw only
      end
      cpu_pkg::op_store:
      begin
        imm_o      = imm_s_type;
        b_is_imm_o = 1'b1;
        if (funct3 == 3'b010)
          class_o = cpu_pkg::cls_store_word;
        else if (funct3 == 3'b000)
          class_o = cpu_pkg::cls_store_byte;
      end
      cpu_pkg::op_branch:
      begin
        imm_o    = imm_b_type;
        alu_op_o = cpu_pkg::alu_sub;
        if (funct3 == 3'b000)
          class_o = cpu_pkg::cls_branch_eq;
        else if (funct3 == 3'b001)
          class_o = cpu_pkg::cls_branch_ne;
      end
      cpu_pkg::op_jal:
      begin
        imm_o    = imm_j_type;
        alu_op_o = cpu_pkg::alu_pc_plus4;
        class_o  = cpu_pkg::cls_jal;
      end
      default: class_o = cpu_pkg::cls_illegal;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/cpu_mem_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_mem_ctrl (
  input  wire                   clk_in,
  input  wire                   rst_in,
  input  wire                   rdy_i,
  input  wire cpu_pkg::mem_op_e op_i,
  input  wire  [`CPU_XLEN-1:0]  addr_i,
  input  wire  [`CPU_XLEN-1:0]  wdata_i,
  input  wire  [7:0]            mem_din_i,
  output logic                  done_o,
  output logic [`CPU_XLEN-1:0]  rdata_o,
  output logic [`CPU_XLEN-1:0]  mem_a_o,
  output logic [7:0]            mem_dout_o,
  output logic                  mem_wr_o
);

  logic [1:0]  cnt_q;  // bytes captured or written so far
  logic        pend_q; // byte cnt_q was addressed last cycle
  logic [23:0] buf_q;  // lower three read bytes
  logic        is_read;
  logic        is_write;
  logic [1:0]  last_idx;
  logic [2:0]  issue_idx;
  logic [1:0]  offset;

  assign is_read  = (op_i == cpu_pkg::mem_fetch) || (op_i == cpu_pkg::mem_load_word);
  assign is_write = (op_i == cpu_pkg::mem_store_word) || (op_i == cpu_pkg::mem_store_byte);
  assign last_idx = (op_i == cpu_pkg::mem_store_byte) ? 2'd0 : 2'd3;

  // while a capture is pending the next byte is already addressed
  assign issue_idx = {1'b0, cnt_q} + {2'b00, pend_q};
  assign offset    = issue_idx[2] ? 2'd3 : issue_idx[1:0]; // hold last byte on final capture

  assign mem_a_o    = (op_i == cpu_pkg::mem_none) ? '0 :
                      addr_i + {{(`CPU_XLEN-2){1'b0}}, offset};
  assign mem_dout_o = wdata_i[{cnt_q, 3'b000} +: 8]; // little endian byte lane
  assign mem_wr_o   = is_write && rdy_i;

  assign done_o  = rdy_i && ((is_read && pend_q && (cnt_q == 2'd3)) ||
                             (is_write && (cnt_q == last_idx)));
  assign rdata_o = {mem_din_i, buf_q}; // top byte taken straight from the bus

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      cnt_q  <= 2'd0;
      pend_q <= 1'b0;
    end
    else if (!rdy_i)
      pend_q <= 1'b0; // capture lost, same byte is addressed again
    else if (done_o)
    begin
      cnt_q  <= 2'd0;
      pend_q <= 1'b0;
    end
    else if (is_read)
    begin
      if (pend_q)
        cnt_q <= cnt_q + 2'd1;
      pend_q <= 1'b1;
    end
    else if (is_write)
      cnt_q <= cnt_q + 2'd1;
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_i && is_read && pend_q && (cnt_q != 2'd3))
      buf_q[{cnt_q, 3'b000} +: 8] <= mem_din_i;
  end

  a_no_wr_paused: assert property (@(posedge clk_in) disable iff (rst_in)
    mem_wr_o |-> (rdy_i && (cnt_q <= last_idx)))
    else $error("memory write while rdy is low or past the last byte");

  a_word_align: assert property (@(posedge clk_in) disable iff (rst_in)
    (op_i inside {cpu_pkg::mem_fetch, cpu_pkg::mem_load_word, cpu_pkg::mem_store_word})
    |-> (addr_i[1:0] == 2'b00))
    else $error("misaligned word access at %h", addr_i);

  // requester must hold the request until done
  a_req_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    ((op_i != cpu_pkg::mem_none) && !done_o) |=> ($stable(op_i) && $stable(addr_i)))
    else $error("memory request changed before done");

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_jal    = 7'b1101111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_and      = 4'd2,
    alu_or       = 4'd3,
    alu_xor      = 4'd4,
    alu_slt      = 4'd5,
    alu_pass_b   = 4'd6, // lui
    alu_pc_plus4 = 4'd7  // jal link value
  } alu_op_e;

  typedef enum logic [3:0] {
    cls_reg_alu    = 4'd0,
    cls_imm_alu    = 4'd1,
    cls_lui        = 4'd2,
    cls_load       = 4'd3,
    cls_store_word = 4'd4,
    cls_store_byte = 4'd5,
    cls_branch_eq  = 4'd6,
    cls_branch_ne  = 4'd7,
    cls_jal        = 4'd8,
    cls_illegal    = 4'd9
  } inst_class_e;

  // requests from the sequencer to the byte bus controller
  typedef enum logic [2:0] {
    mem_none       = 3'd0,
    mem_fetch      = 3'd1,
    mem_load_word  = 3'd2,
    mem_store_word = 3'd3,
    mem_store_byte = 3'd4
  } mem_op_e;

endpackage

`default_nettype wire

/* rtl/cpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_regfile (
  input  wire                  clk_in,
  input  wire                  rst_in,
  input  wire                  rdy_i,
  input  wire  [4:0]           raddr1_i,
  input  wire  [4:0]           raddr2_i,
  input  wire                  we_i,
  input  wire  [4:0]           waddr_i,
  input  wire  [`CPU_XLEN-1:0] wdata_i,
  output logic [`CPU_XLEN-1:0] rdata1_o,
  output logic [`CPU_XLEN-1:0] rdata2_o,
  output logic [`CPU_XLEN-1:0] dbg_o
);

  logic [`CPU_XLEN-1:0] regs_q [32];

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (rdy_i && we_i && (waddr_i != 5'd0)) // x0 never takes a write
      regs_q[waddr_i] <= wdata_i;
  end

  // asynchronous read ports, x0 stays zero from reset
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];
  assign dbg_o    = regs_q[`CPU_DBG_REG];

  a_x0_zero: assert property (@(posedge clk_in) disable iff (rst_in)
    ((raddr1_i != 5'd0) || (rdata1_o == '0)) && ((raddr2_i != 5'd0) || (rdata2_o == '0)))
    else $error("x0 observed nonzero");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the cpu testbench with verilator and run it
# the exit status is the simulator's, nonzero on any failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cpu_tb \
  -Mdir obj_dir \
  -f compile.f

./obj_dir/Vcpu_tb

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;

  localparam int ram_bytes       = 131072;
  localparam int cycles_per_inst = 60;
  localparam int test_margin     = 400; // reset plus slack per program
  localparam int ref_limit       = 20000;

  logic        clk_in = 1'b0;
  logic        rst_in;
  logic        rdy_in;
  logic [7:0]  mem_din;
  logic [7:0]  mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  logic [31:0] dbgreg;

  logic [7:0]  mem [ram_bytes];     // ram behind the dut bus
  logic [7:0]  ref_mem [ram_bytes]; // reference model's own copy
  logic [31:0] prog [$];
  logic [7:0]  act_log [$];
  logic [7:0]  exp_log [$];
  logic [31:0] exp_a0;
  logic        stopped;
  logic        pause_en;
  int          cycles = 0;
  int          budget = 0;

  cpu u_cpu (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
    .mem_din_i(mem_din), .mem_dout_o(mem_dout), .mem_a_o(mem_a),
    .mem_wr_o(mem_wr), .dbgreg_dout_o(dbgreg)
  );

  always #5 clk_in = ~clk_in;

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Checks failed");
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $fatal(1);
    end
  endtask

  // byte bus model, read data one cycle after the address
  always @(posedge clk_in)
  begin
    mem_din <= mem[mem_a[16:0]];
    rdy_in  <= pause_en ? ($urandom_range(99) >= 30) : 1'b1; // about 30% low
    if (!rst_in)
    begin
      check_equal(32'(mem_wr && !rdy_in), 32'd0, "memory write while rdy_in low");
      if (mem_wr)
      begin
        if (mem_a == `CPU_IO_OUT_ADDR)
        begin
          if (mem_dout != 8'h00)
            act_log.push_back(mem_dout);
        end
        else if (mem_a == `CPU_IO_STOP_ADDR)
          stopped = 1'b1;
        else if (mem_a < ram_bytes)
          mem[mem_a[16:0]] = mem_dout;
      end
    end
  end

  // watchdog against the summed budget of all programs so far
  always @(posedge clk_in)
  begin
    cycles <= cycles + 1;
    if (cycles > budget)
    begin
      $display("Checks failed");
      $display("timeout after %0d cycles, program never wrote the stop address", cycles);
      $fatal(1);
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input int rs1,
                                         input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input int rd);
    return {imm, 5'(rd), 7'b0110111};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
  endfunction

  // random alu op into x1..x28, then its low byte to the output port
  task automatic add_random_alu();
    int          sel;
    int          rd;
    int          rs1;
    int          rs2;
    logic [11:0] imm;
    sel = $urandom_range(10);
    rd  = $urandom_range(28, 1);
    rs1 = $urandom_range(29);
    rs2 = $urandom_range(29);
    imm = 12'($urandom);
    case (sel)
      0: prog.push_back(r_type(7'h00, rs2, rs1, 3'b000, rd));
      1: prog.push_back(r_type(7'h20, rs2, rs1, 3'b000, rd)); // sub
      2: prog.push_back(r_type(7'h00, rs2, rs1, 3'b111, rd));
      3: prog.push_back(r_type(7'h00, rs2, rs1, 3'b110, rd));
      4: prog.push_back(r_type(7'h00, rs2, rs1, 3'b100, rd));
      5: prog.push_back(r_type(7'h00, rs2, rs1, 3'b010, rd)); // slt
      6: prog.push_back(i_type(imm, rs1, 3'b000, rd, 7'b0010011));
      7: prog.push_back(i_type(imm, rs1, 3'b111, rd, 7'b0010011));
      8: prog.push_back(i_type(imm, rs1, 3'b110, rd, 7'b0010011));
      9: prog.push_back(i_type(imm, rs1, 3'b100, rd, 7'b0010011));
      default: prog.push_back(lui_word(20'($urandom), rd));
    endcase
    prog.push_back(s_type(12'd0, rd, 31, 3'b000));
  endtask

  task automatic add_random_mem();
    int sel;
    int rd;
    sel = $urandom_range(2);
    rd  = $urandom_range(28, 1);
    case (sel)
      0: prog.push_back(s_type(12'(4 * $urandom_range(63)), $urandom_range(29), 30, 3'b010));
      1: prog.push_back(s_type(12'($urandom_range(255)), $urandom_range(29), 30, 3'b000));
      default:
      begin
        prog.push_back(i_type(12'(4 * $urandom_range(63)), 30, 3'b010, rd, 7'b0000011));
        prog.push_back(s_type(12'd0, rd, 31, 3'b000)); // loaded value to output
      end
    endcase
  endtask

  task automatic add_random_flow();
    int sel;
    int start;
    sel = $urandom_range(3);
    case (sel)
      0:
      begin
        prog.push_back(i_type(12'($urandom_range(6, 2)), 0, 3'b000, 29, 7'b0010011));
        start = prog.size(); // loop head
        add_random_alu();
        prog.push_back(i_type(12'($urandom_range(15, 1)), 10, 3'b000, 10, 7'b0010011));
        prog.push_back(s_type(12'd0, 10, 31, 3'b000));
        prog.push_back(i_type(12'hfff, 29, 3'b000, 29, 7'b0010011));
        prog.push_back(b_type(13'(4 * (start - prog.size())), 0, 29, 3'b001));
      end
      1, 2:
      begin
        // beq or bne over one addi, taken or not
        prog.push_back(b_type(13'd8, $urandom_range(29), $urandom_range(29), 3'(sel - 1)));
        prog.push_back(i_type(12'd5, 10, 3'b000, 10, 7'b0010011));
        prog.push_back(s_type(12'd0, 10, 31, 3'b000));
      end
      default:
      begin
        prog.push_back(jal_word(21'd8, 1));
        prog.push_back(i_type(12'd3, 10, 3'b000, 10, 7'b0010011));
        prog.push_back(s_type(12'd0, 1, 31, 3'b000)); // link value
      end
    endcase
  endtask

  task automatic build_program(input int kind);
    prog.delete();
    prog.push_back(lui_word(20'(`CPU_IO_OUT_ADDR >> 12), 31));
    prog.push_back(lui_word(20'h00010, 30)); // data area at 0x10000
    repeat (6) add_random_alu();
    repeat (30)
      case (kind)
        0: add_random_alu();
        1:
          if ($urandom_range(2) == 0)
            add_random_alu();
          else
            add_random_mem();
        default: add_random_flow();
      endcase
    prog.push_back(s_type(12'(`CPU_IO_STOP_ADDR - `CPU_IO_OUT_ADDR), 0, 31, 3'b000));
    prog.push_back(jal_word(21'd0, 0)); // park
  endtask

  task automatic load_program();
    logic [7:0] fill;
    for (int a = 0; a < ram_bytes; a++)
    begin
      fill            = 8'(a ^ (a >> 8) ^ (a >> 16) ^ 8'h5a);
      mem[17'(a)]     = fill;
      ref_mem[17'(a)] = fill;
    end
    foreach (prog[i])
      for (int k = 0; k < 4; k++)
      begin
        mem[17'(4 * i + k)]     = prog[i][5'(8 * k) +: 8];
        ref_mem[17'(4 * i + k)] = prog[i][5'(8 * k) +: 8];
      end
  endtask

  function automatic logic ref_store(input logic [31:0] addr, input logic [7:0] data);
    if (addr == `CPU_IO_OUT_ADDR)
    begin
      if (data != 8'h00)
        exp_log.push_back(data);
    end
    else if (addr == `CPU_IO_STOP_ADDR)
      return 1'b1;
    else if (addr < ram_bytes)
      ref_mem[addr[16:0]] = data;
    return 1'b0;
  endfunction

  // rv32i interpreter for the subset, returns executed instruction count
  function automatic int run_reference();
    logic [31:0] rf [32];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr_rd;
    logic        stop;
    int          nbytes;
    int          count;
    for (int r = 0; r < 32; r++)
      rf[5'(r)] = '0;
    pc    = `CPU_RESET_PC;
    stop  = 1'b0;
    count = 0;
    exp_log.delete();
    while (!stop && (count < ref_limit))
    begin
      inst = {ref_mem[17'(pc + 3)], ref_mem[17'(pc + 2)], ref_mem[17'(pc + 1)],
              ref_mem[pc[16:0]]};
      a       = rf[inst[19:15]];
      b       = rf[inst[24:20]];
      imm     = {{20{inst[31]}}, inst[31:20]};
      next_pc = pc + 4;
      wr_rd   = 1'b1;
      res     = '0;
      case (inst[6:0])
        7'b0110111: res = {inst[31:12], 12'h000};
        7'b0010011:
          case (inst[14:12])
            3'b000:  res = a + imm;
            3'b111:  res = a & imm;
            3'b110:  res = a | imm;
            default: res = a ^ imm;
          endcase
        7'b0110011:
          case (inst[14:12])
            3'b000:  res = inst[30] ? (a - b) : (a + b);
            3'b111:  res = a & b;
            3'b110:  res = a | b;
            3'b100:  res = a ^ b;
            default: res = {31'b0, $signed(a) < $signed(b)};
          endcase
        7'b0000011:
        begin
          addr = a + imm;
          res  = {ref_mem[17'(addr + 3)], ref_mem[17'(addr + 2)], ref_mem[17'(addr + 1)],
                  ref_mem[addr[16:0]]};
        end
        7'b0100011:
        begin
          wr_rd  = 1'b0;
          addr   = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          nbytes = (inst[14:12] == 3'b010) ? 4 : 1;
          for (int k = 0; k < nbytes; k++)
            if (!stop)
              stop = ref_store(addr + 32'(k), b[5'(8 * k) +: 8]);
        end
        7'b1100011:
        begin
          wr_rd = 1'b0;
          if ((a == b) != inst[12]) // funct3 bit 0 set means bne
            next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        7'b1101111:
        begin
          res     = pc + 4;
          next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: wr_rd = 1'b0;
      endcase
      if (wr_rd && (inst[11:7] != 5'd0))
        rf[inst[11:7]] = res;
      pc    = next_pc;
      count = count + 1;
    end
    exp_a0 = rf[`CPU_DBG_REG];
    return count;
  endfunction

  task automatic reset_dut();
    rst_in <= 1'b1;
    @(posedge clk_in);
    repeat (15)
    begin
      @(posedge clk_in);
      check_equal(32'(mem_wr), 32'd0, "mem_wr during reset");
    end
    rst_in <= 1'b0;
    @(posedge clk_in);
    check_equal(mem_a, `CPU_RESET_PC, "first fetch address after reset");
    check_equal(32'(mem_wr), 32'd0, "mem_wr after reset");
  endtask

  task automatic run_test(input int kind, input logic paused);
    int n;
    build_program(kind);
    load_program();
    n = run_reference();
    if (n >= ref_limit)
    begin
      $display("Checks failed");
      $display("reference model never reached the stop address");
      $fatal(1);
    end
    budget   = budget + n * cycles_per_inst + test_margin;
    stopped  = 1'b0;
    pause_en <= paused;
    act_log.delete();
    reset_dut();
    while (!stopped)
      @(posedge clk_in);
    check_equal(32'(act_log.size()), 32'(exp_log.size()), "number of output bytes");
    foreach (exp_log[i])
      check_equal(32'(act_log[i]), 32'(exp_log[i]), $sformatf("output byte %0d", i));
    check_equal(dbgreg, exp_a0, "final a0 on dbgreg_dout");
    for (int a = 0; a < ram_bytes; a++)
      if (mem[17'(a)] !== ref_mem[17'(a)])
        check_equal(32'(mem[17'(a)]), 32'(ref_mem[17'(a)]), $sformatf("ram byte at %h", a));
  endtask

  initial
  begin
    void'($urandom(1));
    rst_in   <= 1'b1;
    rdy_in   <= 1'b1;
    mem_din  <= 8'h00;
    pause_en <= 1'b0;
    stopped  = 1'b0;
    for (int p = 0; p < 2; p++) // second pass with random pauses
      for (int kind = 0; kind < 3; kind++)
        repeat (2)
          run_test(kind, p[0]);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
